//--- rtl/perf_pkg.sv
// Opcode and mix-category enums, collection states, mix vector type, marker NOPs, UART read word
package perf_pkg;

    ////////////////////////////////////////
    // Instruction decode

    // Opcode field taken from instruction bits 6:2
    typedef enum logic [4:0] {
        OP_LOAD      = 5'b00000,
        OP_FPU_LOAD  = 5'b00001,
        OP_FENCE     = 5'b00011,
        OP_ARITH_IMM = 5'b00100,
        OP_AUIPC     = 5'b00101,
        OP_STORE     = 5'b01000,
        OP_FPU_STORE = 5'b01001,
        OP_AMO       = 5'b01011,
        OP_ARITH     = 5'b01100,
        OP_LUI       = 5'b01101,
        OP_FPU_MADD  = 5'b10000,
        OP_FPU_MSUB  = 5'b10001,
        OP_FPU_NMSUB = 5'b10010,
        OP_FPU_NMADD = 5'b10011,
        OP_FPU_OP    = 5'b10100,
        OP_BRANCH    = 5'b11000,
        OP_JALR      = 5'b11001,
        OP_JAL       = 5'b11011,
        OP_SYSTEM    = 5'b11100
    } opcode_t;

    ////////////////////////////////////////
    // Instruction mix

    // Bit positions inside a mix vector
    typedef enum logic [2:0] {
        MIX_ALU,
        MIX_BR,
        MIX_MUL,
        MIX_DIV,
        MIX_LOAD,
        MIX_STORE,
        MIX_FPU,
        MIX_MISC
    } mix_cat_t;

    localparam int NUM_MIX = 8;

    // One bit per category
    // AMO sets both the load and the store bit
    typedef logic [NUM_MIX-1:0] mix_vec_t;

    ////////////////////////////////////////
    // Collection window

    typedef enum logic [1:0] {
        COLL_IDLE,
        COLL_ACTIVE,
        COLL_DONE
    } coll_state_t;

    // Marker NOPs encoded as addi x0 with distinct immediates
    localparam logic [31:0] START_NOP = 32'h00C00013;
    localparam logic [31:0] END_NOP   = 32'h00D00013;

    ////////////////////////////////////////
    // Console UART

    // Status word handed back on every read
    localparam logic [31:0] UART_READ_DATA = 32'hFFFFFF21;

endpackage

//--- rtl/retire_classifier.sv
// Retire classifier with per-port instruction mix decode and registered marker detection
`timescale 1ns/1ns

module retire_classifier #(
    parameter int RETIRE_PORTS = 2
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic [RETIRE_PORTS-1:0] retire_valid,
    input  logic [31:0]             retire_instr [RETIRE_PORTS],
    output perf_pkg::mix_vec_t      mix_vec [RETIRE_PORTS],
    output logic                    start_seen,
    output logic                    end_seen
);
    import perf_pkg::*;

    opcode_t  opcode [RETIRE_PORTS];
    logic     is_mul [RETIRE_PORTS];
    logic     is_div [RETIRE_PORTS];
    mix_vec_t mix_next [RETIRE_PORTS];
    logic     start_next;
    logic     end_next;

    ////////////////////////////////////////
    // Decode

    always_comb begin
        start_next = 1'b0;
        end_next = 1'b0;
        for (int p = 0; p < RETIRE_PORTS; p++) begin
            opcode[p] = opcode_t'(retire_instr[p][6:2]);

            // M extension shares the ARITH opcode
            // bit 25 marks it and bit 14 splits mul from div
            is_mul[p] = (opcode[p] == OP_ARITH) & retire_instr[p][25] & ~retire_instr[p][14];
            is_div[p] = (opcode[p] == OP_ARITH) & retire_instr[p][25] & retire_instr[p][14];

            mix_next[p] = '0;
            case (opcode[p])
                OP_ARITH, OP_ARITH_IMM, OP_AUIPC, OP_LUI: begin
                    mix_next[p][MIX_ALU] = ~(is_mul[p] | is_div[p]);
                end
                OP_BRANCH, OP_JAL, OP_JALR: begin
                    mix_next[p][MIX_BR] = 1'b1;
                end
                OP_LOAD, OP_FPU_LOAD: begin
                    mix_next[p][MIX_LOAD] = 1'b1;
                end
                OP_STORE, OP_FPU_STORE: begin
                    mix_next[p][MIX_STORE] = 1'b1;
                end
                OP_AMO: begin
                    // Read-modify-write counts on both sides
                    mix_next[p][MIX_LOAD] = 1'b1;
                    mix_next[p][MIX_STORE] = 1'b1;
                end
                OP_FPU_MADD, OP_FPU_MSUB, OP_FPU_NMSUB, OP_FPU_NMADD, OP_FPU_OP: begin
                    mix_next[p][MIX_FPU] = 1'b1;
                end
                OP_SYSTEM, OP_FENCE: begin
                    mix_next[p][MIX_MISC] = 1'b1;
                end
                default: begin
                    mix_next[p] = '0;
                end
            endcase
            mix_next[p][MIX_MUL] = is_mul[p];
            mix_next[p][MIX_DIV] = is_div[p];

            // Idle ports contribute nothing downstream
            if (!retire_valid[p]) begin
                mix_next[p] = '0;
            end

            start_next |= retire_valid[p] & (retire_instr[p] == START_NOP);
            end_next |= retire_valid[p] & (retire_instr[p] == END_NOP);
        end
    end

    ////////////////////////////////////////
    // Output registers

    always_ff @(posedge clk) begin
        if (rst) begin
            mix_vec <= '{default: '0};
            start_seen <= 1'b0;
            end_seen <= 1'b0;
        end else begin
            mix_vec <= mix_next;
            start_seen <= start_next;
            end_seen <= end_next;
        end
    end

endmodule

//--- rtl/mix_stats.sv
// Collection window FSM with per-category mix counters and total retire counter
`timescale 1ns/1ns

module mix_stats #(
    parameter int RETIRE_PORTS = 2,
    parameter int COUNT_W = 32
) (
    input  logic               clk,
    input  logic               rst,
    input  perf_pkg::mix_vec_t mix_vec [RETIRE_PORTS],
    input  logic               start_seen,
    input  logic               end_seen,
    output logic               collecting,
    output logic [COUNT_W-1:0] mix_count [perf_pkg::NUM_MIX],
    output logic [COUNT_W-1:0] retire_count
);
    import perf_pkg::*;

    // Wide enough to hold a full count of ports
    localparam int SUM_W = $clog2(RETIRE_PORTS + 1);

    coll_state_t      state;
    coll_state_t      state_next;
    logic [SUM_W-1:0] cat_sum [NUM_MIX];
    logic [SUM_W-1:0] port_sum;
    logic             count_en;

    ////////////////////////////////////////
    // Per-cycle sums across ports

    always_comb begin
        port_sum = '0;
        for (int c = 0; c < NUM_MIX; c++) begin
            cat_sum[c] = '0;
        end
        for (int p = 0; p < RETIRE_PORTS; p++) begin
            for (int c = 0; c < NUM_MIX; c++) begin
                cat_sum[c] += SUM_W'(mix_vec[p][c]);
            end
            // A port that retired anything sets at least one bit
            port_sum += SUM_W'(|mix_vec[p]);
        end
    end

    ////////////////////////////////////////
    // Window FSM

    always_comb begin
        state_next = state;
        case (state)
            COLL_IDLE: begin
                if (start_seen) begin
                    state_next = COLL_ACTIVE;
                end
            end
            COLL_ACTIVE: begin
                // Start outranks end when both land together
                if (start_seen) begin
                    state_next = COLL_ACTIVE;
                end else if (end_seen) begin
                    state_next = COLL_DONE;
                end
            end
            COLL_DONE: begin
                if (start_seen) begin
                    state_next = COLL_ACTIVE;
                end
            end
            default: begin
                state_next = COLL_IDLE;
            end
        endcase
    end

    // Marker cycles themselves are never counted
    assign count_en = (state == COLL_ACTIVE) & ~end_seen;
    assign collecting = (state == COLL_ACTIVE);

    ////////////////////////////////////////
    // Counters

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= COLL_IDLE;
            mix_count <= '{default: '0};
            retire_count <= '0;
        end else begin
            state <= state_next;
            if (start_seen) begin
                // Fresh window on every start marker
                mix_count <= '{default: '0};
                retire_count <= '0;
            end else if (count_en) begin
                for (int c = 0; c < NUM_MIX; c++) begin
                    mix_count[c] <= mix_count[c] + COUNT_W'(cat_sum[c]);
                end
                retire_count <= retire_count + COUNT_W'(port_sum);
            end
        end
    end

endmodule

//--- rtl/uart_axi_responder.sv
// AXI-lite console UART responder with write byte strobe and fixed read status word
`timescale 1ns/1ns

module uart_axi_responder (
    input  logic        clk,
    input  logic        rst,
    input  logic        awvalid,
    input  logic        wvalid,
    input  logic        bready,
    input  logic        arvalid,
    input  logic        rready,
    input  logic [31:0] wdata,
    output logic        awready,
    output logic        wready,
    output logic        bvalid,
    output logic        arready,
    output logic        rvalid,
    output logic [31:0] rdata,
    output logic        uart_write,
    output logic [7:0]  uart_byte
);
    import perf_pkg::*;

    typedef enum logic [1:0] {
        WR_ADDR,
        WR_DATA,
        WR_RESP
    } wr_state_t;

    typedef enum logic {
        RD_ADDR,
        RD_DATA
    } rd_state_t;

    wr_state_t wr_state;
    rd_state_t rd_state;
    logic      aw_fire;
    logic      w_fire;
    logic      b_fire;
    logic      ar_fire;
    logic      r_fire;

    ////////////////////////////////////////
    // Write channel

    // One write in flight, each phase owns its ready or valid
    assign awready = (wr_state == WR_ADDR);
    assign wready  = (wr_state == WR_DATA);
    assign bvalid  = (wr_state == WR_RESP);

    assign aw_fire = awvalid & awready;
    assign w_fire  = wvalid & wready;
    assign b_fire  = bvalid & bready;

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_state <= WR_ADDR;
            uart_write <= 1'b0;
        end else begin
            // Strobe lines up with bvalid rising
            uart_write <= w_fire;
            case (wr_state)
                WR_ADDR: begin
                    if (aw_fire) begin
                        wr_state <= WR_DATA;
                    end
                end
                WR_DATA: begin
                    if (w_fire) begin
                        wr_state <= WR_RESP;
                    end
                end
                WR_RESP: begin
                    if (b_fire) begin
                        wr_state <= WR_ADDR;
                    end
                end
                default: begin
                    wr_state <= WR_ADDR;
                end
            endcase
        end
    end

    // Low byte of the data beat goes to the console
    always_ff @(posedge clk) begin
        if (w_fire) begin
            uart_byte <= wdata[7:0];
        end
    end

    ////////////////////////////////////////
    // Read channel

    assign arready = (rd_state == RD_ADDR);
    assign rvalid  = (rd_state == RD_DATA);
    assign ar_fire = arvalid & arready;
    assign r_fire  = rvalid & rready;
    assign rdata   = UART_READ_DATA;

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_state <= RD_ADDR;
        end else if (ar_fire) begin
            rd_state <= RD_DATA;
        end else if (r_fire) begin
            rd_state <= RD_ADDR;
        end
    end

endmodule

//--- rtl/sim_monitor_top.sv
// Retire-trace performance monitor top with classifier, mix statistics and console UART
`timescale 1ns/1ns

module sim_monitor_top #(
    parameter int RETIRE_PORTS = 2,
    parameter int COUNT_W = 32
) (
    input  logic                    clk,
    input  logic                    rst,
    // Retire trace
    input  logic [RETIRE_PORTS-1:0] retire_valid,
    input  logic [31:0]             retire_instr [RETIRE_PORTS],
    // Statistics
    output logic                    collecting,
    output logic [COUNT_W-1:0]      mix_count [perf_pkg::NUM_MIX],
    output logic [COUNT_W-1:0]      retire_count,
    // Console UART bus
    input  logic                    awvalid,
    input  logic                    wvalid,
    input  logic                    bready,
    input  logic                    arvalid,
    input  logic                    rready,
    input  logic [31:0]             wdata,
    output logic                    awready,
    output logic                    wready,
    output logic                    bvalid,
    output logic                    arready,
    output logic                    rvalid,
    output logic [31:0]             rdata,
    output logic                    uart_write,
    output logic [7:0]              uart_byte
);
    import perf_pkg::*;

    mix_vec_t mix_vec [RETIRE_PORTS];
    logic     start_seen;
    logic     end_seen;

    retire_classifier #(
        .RETIRE_PORTS(RETIRE_PORTS)
    ) i_retire_classifier (
        .clk(clk),
        .rst(rst),
        .retire_valid(retire_valid),
        .retire_instr(retire_instr),
        .mix_vec(mix_vec),
        .start_seen(start_seen),
        .end_seen(end_seen)
    );

    mix_stats #(
        .RETIRE_PORTS(RETIRE_PORTS),
        .COUNT_W(COUNT_W)
    ) i_mix_stats (
        .clk(clk),
        .rst(rst),
        .mix_vec(mix_vec),
        .start_seen(start_seen),
        .end_seen(end_seen),
        .collecting(collecting),
        .mix_count(mix_count),
        .retire_count(retire_count)
    );

    uart_axi_responder i_uart_axi_responder (
        .clk(clk),
        .rst(rst),
        .awvalid(awvalid),
        .wvalid(wvalid),
        .bready(bready),
        .arvalid(arvalid),
        .rready(rready),
        .wdata(wdata),
        .awready(awready),
        .wready(wready),
        .bvalid(bvalid),
        .arready(arready),
        .rvalid(rvalid),
        .rdata(rdata),
        .uart_write(uart_write),
        .uart_byte(uart_byte)
    );

endmodule

//--- verif/monitor_sva.sv
// UART handshake assertions bound to the AXI-lite responder
`timescale 1ns/1ns

module monitor_sva (
    input logic clk,
    input logic rst,
    input logic awready,
    input logic wready,
    input logic bvalid,
    input logic bready,
    input logic uart_write
);
    int fail_count = 0;

    // Address and data phases never overlap
    aw_w_exclusive: assert property (@(posedge clk) disable iff (rst) !(awready && wready))
        else begin
            $error("awready and wready were high in the same cycle");
            fail_count++;
        end

    b_hold: assert property (@(posedge clk) disable iff (rst) bvalid && !bready |=> bvalid)
        else begin
            $error("bvalid dropped before bready was seen");
            fail_count++;
        end

    // Console strobe only on the first response cycle
    write_on_b_rise: assert property (@(posedge clk) disable iff (rst)
        uart_write |-> bvalid && !$past(bvalid))
        else begin
            $error("uart_write pulsed without bvalid rising");
            fail_count++;
        end

endmodule

bind uart_axi_responder monitor_sva i_monitor_sva (
    .clk(clk),
    .rst(rst),
    .awready(awready),
    .wready(wready),
    .bvalid(bvalid),
    .bready(bready),
    .uart_write(uart_write)
);

//--- verif/monitor_checker.sv
// Reference model of mix counts, collection window and UART timing, compared with DUT outputs
`timescale 1ns/1ns

module monitor_checker #(
    parameter int RETIRE_PORTS = 2,
    parameter int COUNT_W = 32
) (
    input logic                    clk,
    input logic                    rst,
    input logic [RETIRE_PORTS-1:0] retire_valid,
    input logic [31:0]             retire_instr [RETIRE_PORTS],
    input logic                    collecting,
    input logic [COUNT_W-1:0]      mix_count [perf_pkg::NUM_MIX],
    input logic [COUNT_W-1:0]      retire_count,
    input logic                    awvalid,
    input logic                    wvalid,
    input logic                    bready,
    input logic                    arvalid,
    input logic                    rready,
    input logic [31:0]             wdata,
    input logic                    awready,
    input logic                    wready,
    input logic                    bvalid,
    input logic                    arready,
    input logic                    rvalid,
    input logic [31:0]             rdata,
    input logic                    uart_write,
    input logic [7:0]              uart_byte,
    input logic                    table_check,
    input logic [COUNT_W-1:0]      table_total
);
    import perf_pkg::*;

    int                 errors = 0;
    logic               armed = 1'b0;
    mix_vec_t           cur_vec [RETIRE_PORTS];
    logic               cur_start;
    logic               cur_end;
    mix_vec_t           s1_vec [RETIRE_PORTS];
    logic               s1_start;
    logic               s1_end;
    logic [COUNT_W-1:0] add_cat [NUM_MIX];
    logic [COUNT_W-1:0] add_ret;
    coll_state_t        m_state;
    logic [COUNT_W-1:0] m_count [NUM_MIX];
    logic [COUNT_W-1:0] m_retired;
    logic [1:0]         m_wr;
    logic               m_rd;
    logic               m_uart_write;
    logic [7:0]         m_byte;
    logic               check_d1;
    logic               check_d2;
    logic [COUNT_W-1:0] total_d1;
    logic [COUNT_W-1:0] total_d2;

    // Category bits straight from the opcode field and the M-extension bits
    function automatic mix_vec_t classify(input logic [31:0] instr);
        mix_vec_t   v;
        logic [4:0] op;
        logic       m_ext;
        v = '0;
        op = instr[6:2];
        m_ext = (op == 5'b01100) && instr[25];
        v[MIX_MUL] = m_ext && !instr[14];
        v[MIX_DIV] = m_ext && instr[14];
        v[MIX_ALU] = (op inside {5'b01100, 5'b00100, 5'b00101, 5'b01101}) && !m_ext;
        v[MIX_BR] = op inside {5'b11000, 5'b11001, 5'b11011};
        v[MIX_LOAD] = op inside {5'b00000, 5'b00001, 5'b01011};
        v[MIX_STORE] = op inside {5'b01000, 5'b01001, 5'b01011};
        v[MIX_FPU] = op inside {[5'b10000:5'b10100]};
        v[MIX_MISC] = op inside {5'b11100, 5'b00011};
        return v;
    endfunction

    task automatic check_value(input string what, input logic [63:0] got,
                               input logic [63:0] expected);
        if (got !== expected) begin
            errors++;
            $display("mismatch at %0t: %s is %0h, expected %0h", $time, what, got, expected);
        end
    endtask

    always_comb begin
        cur_start = 1'b0;
        cur_end = 1'b0;
        add_ret = '0;
        for (int c = 0; c < NUM_MIX; c++) begin
            add_cat[c] = '0;
        end
        for (int p = 0; p < RETIRE_PORTS; p++) begin
            cur_vec[p] = retire_valid[p] ? classify(retire_instr[p]) : '0;
            cur_start |= retire_valid[p] && (retire_instr[p] == 32'h00C00013);
            cur_end |= retire_valid[p] && (retire_instr[p] == 32'h00D00013);
            for (int c = 0; c < NUM_MIX; c++) begin
                add_cat[c] += COUNT_W'(s1_vec[p][c]);
            end
            add_ret += COUNT_W'(s1_vec[p] != '0);
        end
    end

    ////////////////////////////////////////
    // Model update

    always @(posedge clk) begin
        if (rst) begin
            armed <= 1'b1;
            s1_vec <= '{default: '0};
            s1_start <= 1'b0;
            s1_end <= 1'b0;
            m_state <= COLL_IDLE;
            m_count <= '{default: '0};
            m_retired <= '0;
            m_wr <= 2'd0;
            m_rd <= 1'b0;
            m_uart_write <= 1'b0;
            check_d1 <= 1'b0;
            check_d2 <= 1'b0;
        end else begin
            s1_vec <= cur_vec;
            s1_start <= cur_start;
            s1_end <= cur_end;
            // Start marker restarts the window, even alongside an end marker
            if (s1_start) begin
                m_state <= COLL_ACTIVE;
                m_count <= '{default: '0};
                m_retired <= '0;
            end else if (m_state == COLL_ACTIVE && s1_end) begin
                m_state <= COLL_DONE;
            end else if (m_state == COLL_ACTIVE) begin
                for (int c = 0; c < NUM_MIX; c++) begin
                    m_count[c] <= m_count[c] + add_cat[c];
                end
                m_retired <= m_retired + add_ret;
            end

            // Write phases 0 address, 1 data, 2 response
            m_uart_write <= wvalid && (m_wr == 2'd1);
            if (wvalid && m_wr == 2'd1) begin
                m_byte <= wdata[7:0];
            end
            case (m_wr)
                2'd0: m_wr <= awvalid ? 2'd1 : 2'd0;
                2'd1: m_wr <= wvalid ? 2'd2 : 2'd1;
                default: m_wr <= bready ? 2'd0 : 2'd2;
            endcase
            m_rd <= m_rd ? !rready : arvalid;

            check_d1 <= table_check;
            check_d2 <= check_d1;
            total_d1 <= table_total;
            total_d2 <= total_d1;
        end
    end

    ////////////////////////////////////////
    // Comparison, away from the rising edge

    always @(negedge clk) begin
        if (armed) begin
            check_value("collecting", 64'(collecting), 64'(m_state == COLL_ACTIVE));
            for (int c = 0; c < NUM_MIX; c++) begin
                check_value($sformatf("mix_count[%0d]", c), 64'(mix_count[c]), 64'(m_count[c]));
            end
            check_value("retire_count", 64'(retire_count), 64'(m_retired));
            if (check_d2) begin
                check_value("retire_count against table", 64'(retire_count), 64'(total_d2));
            end
            check_value("awready", 64'(awready), 64'(m_wr == 2'd0));
            check_value("wready", 64'(wready), 64'(m_wr == 2'd1));
            check_value("bvalid", 64'(bvalid), 64'(m_wr == 2'd2));
            check_value("arready", 64'(arready), 64'(!m_rd));
            check_value("rvalid", 64'(rvalid), 64'(m_rd));
            check_value("uart_write", 64'(uart_write), 64'(m_uart_write));
            if (m_uart_write) begin
                check_value("uart_byte", 64'(uart_byte), 64'(m_byte));
            end
            if (m_rd) begin
                check_value("rdata", 64'(rdata), 64'h0000_0000_FFFF_FF21);
            end
        end
    end

endmodule

//--- verif/tb_sim_monitor.sv
// Testbench top with clock, reset, retire stimulus table, UART transactions and watchdog
`timescale 1ns/1ns

module tb_sim_monitor;
    import perf_pkg::*;

    localparam int RETIRE_PORTS = 2;
    localparam int COUNT_W = 32;
    localparam int CLK_PERIOD = 100;
    localparam int RESET_CYCLES = 8;
    localparam int NUM_ROWS = 23;
    localparam int NUM_UART = 5;
    localparam int WATCHDOG_CYCLES = (NUM_ROWS + NUM_UART) * 4 + RESET_CYCLES;

    // Sample encodings, one or more per opcode
    localparam logic [31:0] I_ADD    = 32'h002081B3;
    localparam logic [31:0] I_MUL    = 32'h022081B3;
    localparam logic [31:0] I_DIV    = 32'h0220C1B3;
    localparam logic [31:0] I_ADDI   = 32'h00108093;
    localparam logic [31:0] I_LUI    = 32'h000010B7;
    localparam logic [31:0] I_AUIPC  = 32'h00001097;
    localparam logic [31:0] I_BEQ    = 32'h00208463;
    localparam logic [31:0] I_JAL    = 32'h008000EF;
    localparam logic [31:0] I_JALR   = 32'h000080E7;
    localparam logic [31:0] I_LW     = 32'h0000A103;
    localparam logic [31:0] I_FLW    = 32'h0000A107;
    localparam logic [31:0] I_SW     = 32'h0020A023;
    localparam logic [31:0] I_FSW    = 32'h0020A027;
    localparam logic [31:0] I_AMO    = 32'h0020A1AF;
    localparam logic [31:0] I_FADD   = 32'h002081D3;
    localparam logic [31:0] I_FMADD  = 32'h18208143;
    localparam logic [31:0] I_FMSUB  = 32'h18208147;
    localparam logic [31:0] I_FNMSUB = 32'h1820814B;
    localparam logic [31:0] I_FNMADD = 32'h1820814F;
    localparam logic [31:0] I_ECALL  = 32'h00000073;
    localparam logic [31:0] I_FENCE  = 32'h0FF0000F;

    logic                    clk;
    logic                    rst;
    logic [RETIRE_PORTS-1:0] retire_valid;
    logic [31:0]             retire_instr [RETIRE_PORTS];
    logic                    collecting;
    logic [COUNT_W-1:0]      mix_count [NUM_MIX];
    logic [COUNT_W-1:0]      retire_count;
    logic                    awvalid;
    logic                    wvalid;
    logic                    bready;
    logic                    arvalid;
    logic                    rready;
    logic [31:0]             wdata;
    logic                    awready;
    logic                    wready;
    logic                    bvalid;
    logic                    arready;
    logic                    rvalid;
    logic [31:0]             rdata;
    logic                    uart_write;
    logic [7:0]              uart_byte;
    logic                    table_check;
    logic [COUNT_W-1:0]      table_total;

    // Row: port valids, one instruction per port, retire_count once the row is counted
    logic [RETIRE_PORTS-1:0] row_valid [NUM_ROWS];
    logic [31:0]             row_instr [NUM_ROWS][RETIRE_PORTS];
    logic [COUNT_W-1:0]      row_total [NUM_ROWS];
    integer                  seed;
    int                      mismatches;
    int                      assert_fails;

    sim_monitor_top #(
        .RETIRE_PORTS(RETIRE_PORTS),
        .COUNT_W(COUNT_W)
    ) i_sim_monitor_top (.*);

    monitor_checker #(
        .RETIRE_PORTS(RETIRE_PORTS),
        .COUNT_W(COUNT_W)
    ) i_monitor_checker (.*);

    always #(CLK_PERIOD / 2) clk = ~clk;

    ////////////////////////////////////////
    // Stimulus helpers

    task automatic set_row(input int i, input logic [1:0] v, input logic [31:0] a,
                           input logic [31:0] b, input int total);
        row_valid[i] = v;
        row_instr[i][0] = a;
        row_instr[i][1] = b;
        row_total[i] = COUNT_W'(total);
    endtask

    task automatic load_table();
        set_row(0, 2'b11, I_ADD, I_LW, 0);
        set_row(1, 2'b10, START_NOP, I_ADDI, 0);
        set_row(2, 2'b01, START_NOP, I_SW, 0);
        set_row(3, 2'b11, I_ADD, I_ADDI, 2);
        set_row(4, 2'b11, I_MUL, I_DIV, 4);
        set_row(5, 2'b11, I_LUI, I_AUIPC, 6);
        set_row(6, 2'b11, I_BEQ, I_JAL, 8);
        set_row(7, 2'b01, I_JALR, I_MUL, 9);
        set_row(8, 2'b11, I_LW, I_FLW, 11);
        set_row(9, 2'b11, I_SW, I_FSW, 13);
        set_row(10, 2'b11, I_AMO, I_AMO, 15);
        set_row(11, 2'b11, I_FADD, I_FMADD, 17);
        set_row(12, 2'b11, I_FMSUB, I_FNMSUB, 19);
        set_row(13, 2'b11, I_ECALL, I_FENCE, 21);
        set_row(14, 2'b00, I_ADD, I_ADD, 21);
        set_row(15, 2'b11, END_NOP, I_LW, 21);
        set_row(16, 2'b11, I_ADD, I_DIV, 21);
        set_row(17, 2'b10, I_ADD, START_NOP, 0);
        set_row(18, 2'b11, I_FNMADD, I_SW, 2);
        set_row(19, 2'b11, START_NOP, END_NOP, 0);
        set_row(20, 2'b01, I_DIV, I_ADD, 1);
        set_row(21, 2'b10, I_ADD, END_NOP, 1);
        set_row(22, 2'b00, I_LW, I_SW, 1);
    endtask

    // rd and rs1 never steer the classification, markers stay exact
    function automatic logic [31:0] fill_ignored_fields(input logic [31:0] instr);
        logic [31:0] r;
        r = $random(seed);
        if (instr == START_NOP || instr == END_NOP) begin
            return instr;
        end
        return instr ^ (r & 32'h000F8F80);
    endfunction

    task automatic send_console_byte(input logic [7:0] b, input int hold);
        awvalid = 1'b1;
        while (!awready) @(negedge clk);
        @(negedge clk);
        awvalid = 1'b0;
        wvalid = 1'b1;
        wdata = $random(seed);
        wdata[7:0] = b;
        while (!wready) @(negedge clk);
        @(negedge clk);
        wvalid = 1'b0;
        // Response left pending for a few cycles
        repeat (hold) @(negedge clk);
        bready = 1'b1;
        while (!bvalid) @(negedge clk);
        @(negedge clk);
        bready = 1'b0;
    endtask

    task automatic read_uart_status(input int hold);
        arvalid = 1'b1;
        while (!arready) @(negedge clk);
        @(negedge clk);
        arvalid = 1'b0;
        repeat (hold) @(negedge clk);
        rready = 1'b1;
        while (!rvalid) @(negedge clk);
        @(negedge clk);
        rready = 1'b0;
    endtask

    ////////////////////////////////////////
    // Main sequence

    initial begin
        seed = 33;
        clk = 1'b0;
        rst = 1'b1;
        retire_valid = '0;
        retire_instr = '{default: '0};
        awvalid = 1'b0;
        wvalid = 1'b0;
        wdata = '0;
        bready = 1'b0;
        arvalid = 1'b0;
        rready = 1'b0;
        table_check = 1'b0;
        table_total = '0;
        load_table();
        repeat (RESET_CYCLES) @(negedge clk);
        rst = 1'b0;

        for (int i = 0; i < NUM_ROWS; i++) begin
            retire_valid = row_valid[i];
            for (int p = 0; p < RETIRE_PORTS; p++) begin
                retire_instr[p] = fill_ignored_fields(row_instr[i][p]);
            end
            table_check = 1'b1;
            table_total = row_total[i];
            @(negedge clk);
        end
        retire_valid = '0;
        table_check = 1'b0;
        repeat (3) @(negedge clk);

        send_console_byte(8'h48, 0);
        send_console_byte(8'h69, 2);
        read_uart_status(0);
        read_uart_status(3);
        send_console_byte(8'h0A, 1);
        repeat (2) @(negedge clk);
        #(CLK_PERIOD / 4);

        mismatches = i_monitor_checker.errors;
        assert_fails = i_sim_monitor_top.i_uart_axi_responder.i_monitor_sva.fail_count;
        $display("errors: %0d mismatches, %0d assertion failures", mismatches, assert_fails);
        if (mismatches == 0 && assert_fails == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

    // Watchdog
    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("timeout: test sequence did not complete within %0d cycles", WATCHDOG_CYCLES);
        $display("STATUS: FAIL");
        $finish;
    end

endmodule

//--- src.f
rtl/perf_pkg.sv
rtl/retire_classifier.sv
rtl/mix_stats.sv
rtl/uart_axi_responder.sv
rtl/sim_monitor_top.sv
verif/monitor_sva.sv
verif/monitor_checker.sv
verif/tb_sim_monitor.sv

//--- Makefile
# Verilator lint, simulation and cleanup for the retire-trace monitor

TOP := tb_sim_monitor

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --top-module $(TOP) -f src.f

obj_dir/V$(TOP): src.f $(shell cat src.f)
	verilator --binary --timing --assert --top-module $(TOP) -f src.f

sim: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) +verilator+error+limit+100 > sim.log 2>&1 || true
	@cat sim.log
	@if grep -q "STATUS: FAIL" sim.log || ! grep -q "STATUS: PASS" sim.log; then \
		echo "Simulation failed, see sim.log"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log
